/* hdl/conv_weight_config.svh */
`ifndef CONV_WEIGHT_CONFIG_SVH
`define CONV_WEIGHT_CONFIG_SVH

// bits per weight word
`define CWB_DATA_WIDTH 32

// kernel side, square kernel
`define CWB_KERNEL_DIM 7

// words per kernel
`define CWB_KERNEL_TAPS (`CWB_KERNEL_DIM * `CWB_KERNEL_DIM)

// whole kernels held in the queue, power of two
`define CWB_KERNEL_DEPTH 4

// word counter, wide enough for taps - 1
`define CWB_TAP_COUNT_WIDTH 6

`endif

/* hdl/conv_weight_pkg.sv */
`include "conv_weight_config.svh"

package conv_weight_pkg;

	//////////////////////////////////////////////////////////////////////
	// incoming stream
	//////////////////////////////////////////////////////////////////////

	typedef logic [`CWB_DATA_WIDTH-1:0] weight_word_t;

	typedef struct packed {
		logic         valid;
		weight_word_t data;
	} weight_beat_t;

	//////////////////////////////////////////////////////////////////////
	// kernel views
	//////////////////////////////////////////////////////////////////////

	// taps[i] and rows[i / dim][i % dim] are the same word
	typedef union packed {
		// arrival order, filled by the assembler
		weight_word_t [`CWB_KERNEL_TAPS-1:0] taps;
		// row major, read by the engine
		weight_word_t [`CWB_KERNEL_DIM-1:0][`CWB_KERNEL_DIM-1:0] rows;
	} kernel_t;

	//////////////////////////////////////////////////////////////////////
	// towards the engine
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		// sticky once a kernel has been presented
		logic    valid;
		kernel_t kernel;
	} kernel_port_t;

endpackage

/* hdl/kernel_assembler.sv */
`include "conv_weight_config.svh"

module kernel_assembler (
	input  logic                          clk,
	input  logic                          reset,
	input  conv_weight_pkg::weight_beat_t beat,
	output logic                          kernel_wr,
	output conv_weight_pkg::kernel_t      assembled
);

	localparam logic [`CWB_TAP_COUNT_WIDTH-1:0] last_tap =
		`CWB_TAP_COUNT_WIDTH'(`CWB_KERNEL_TAPS - 1);

	localparam logic [`CWB_TAP_COUNT_WIDTH-1:0] tap_step =
		`CWB_TAP_COUNT_WIDTH'(1);

	// words taken so far in the current kernel
	logic [`CWB_TAP_COUNT_WIDTH-1:0] tap_count;

	logic accept;
	logic kernel_done;

	conv_weight_pkg::kernel_t shifted;

	assign accept = beat.valid;

	// this word closes the kernel
	assign kernel_done = accept && (tap_count == last_tap);

	//////////////////////////////////////////////////////////////////////
	// shift chain
	//////////////////////////////////////////////////////////////////////

	// new word enters at the top tap, everything else moves one down
	always_comb begin
		shifted = assembled;
		for (int i = 0; i < `CWB_KERNEL_TAPS - 1; i++) begin
			shifted.taps[i] = assembled.taps[i + 1];
		end
		shifted.taps[`CWB_KERNEL_TAPS-1] = beat.data;
	end

	// partial kernel is thrown away on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			assembled <= '0;
		end else if (accept) begin
			assembled <= shifted;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word counter
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			tap_count <= '0;
		end else if (accept) begin
			if (tap_count == last_tap) begin
				tap_count <= '0;
			end else begin
				tap_count <= tap_count + tap_step;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// write strobe
	//////////////////////////////////////////////////////////////////////

	// high for the one cycle after the last word,
	// chain holds the whole kernel during that cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_wr <= 1'b0;
		end else begin
			kernel_wr <= kernel_done;
		end
	end

endmodule

/* hdl/kernel_fifo.sv */
`include "conv_weight_config.svh"

module kernel_fifo (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          kernel_wr,
	input  conv_weight_pkg::kernel_t      assembled,
	input  logic                          load_weights,
	output conv_weight_pkg::kernel_port_t kernel_port
);

	localparam int ptr_width   = $clog2(`CWB_KERNEL_DEPTH);
	localparam int count_width = ptr_width + 1;

	localparam logic [ptr_width-1:0]   ptr_step    = ptr_width'(1);
	localparam logic [count_width-1:0] count_step  = count_width'(1);
	localparam logic [count_width-1:0] depth_count = count_width'(`CWB_KERNEL_DEPTH);

	//////////////////////////////////////////////////////////////////////
	// storage and pointers
	//////////////////////////////////////////////////////////////////////

	conv_weight_pkg::kernel_t kernel_mem [`CWB_KERNEL_DEPTH];

	logic [ptr_width-1:0]   wr_ptr;
	logic [ptr_width-1:0]   rd_ptr;
	logic [count_width-1:0] fill_count;

	logic full;
	logic empty;
	logic do_write;
	logic do_read;

	assign full  = (fill_count == depth_count);
	assign empty = (fill_count == '0);

	// write into a full queue is dropped, load on empty is ignored
	assign do_write = kernel_wr && !full;
	assign do_read  = load_weights && !empty;

	always_ff @(posedge clk) begin
		if (do_write) begin
			kernel_mem[wr_ptr] <= assembled;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			wr_ptr <= wr_ptr + ptr_step;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (do_read) begin
			rd_ptr <= rd_ptr + ptr_step;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// occupancy
	//////////////////////////////////////////////////////////////////////

	// simultaneous write and read leaves the count alone
	always_ff @(posedge clk) begin
		if (reset) begin
			fill_count <= '0;
		end else begin
			case ({do_write, do_read})
				2'b10: begin
					fill_count <= fill_count + count_step;
				end
				2'b01: begin
					fill_count <= fill_count - count_step;
				end
				default: begin
					fill_count <= fill_count;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output towards the engine
	//////////////////////////////////////////////////////////////////////

	// oldest kernel lands here on the edge that sees the load
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_port.kernel <= '0;
		end else if (do_read) begin
			kernel_port.kernel <= kernel_mem[rd_ptr];
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_port.valid <= 1'b0;
		end else if (do_read) begin
			kernel_port.valid <= 1'b1;
		end
	end

endmodule

/* hdl/conv_weight_buffer.sv */
module conv_weight_buffer (
	input  logic                          clk,
	input  logic                          reset,
	input  conv_weight_pkg::weight_beat_t beat,
	input  logic                          load_weights,
	output conv_weight_pkg::kernel_port_t kernel_port
);

	//////////////////////////////////////////////////////////////////////
	// assembler to queue
	//////////////////////////////////////////////////////////////////////

	// one cycle strobe, kernel sampled on that edge
	logic kernel_wr;

	conv_weight_pkg::kernel_t assembled;

	//////////////////////////////////////////////////////////////////////
	// word stream into whole kernels
	//////////////////////////////////////////////////////////////////////

	kernel_assembler i_kernel_assembler (
		.clk       (clk),
		.reset     (reset),
		.beat      (beat),
		.kernel_wr (kernel_wr),
		.assembled (assembled)
	);

	//////////////////////////////////////////////////////////////////////
	// kernel queue
	//////////////////////////////////////////////////////////////////////

	// load pulse pops the oldest kernel onto the port
	kernel_fifo i_kernel_fifo (
		.clk          (clk),
		.reset        (reset),
		.kernel_wr    (kernel_wr),
		.assembled    (assembled),
		.load_weights (load_weights),
		.kernel_port  (kernel_port)
	);

endmodule

/* bench/conv_weight_buffer_assertions.sv */
module conv_weight_buffer_assertions (
	input logic                          clk,
	input logic                          reset,
	input logic                          load_weights,
	input logic                          kernel_wr,
	input conv_weight_pkg::kernel_port_t kernel_port
);
	timeunit 1ns;
	timeprecision 1ps;

	// one flag per property
	logic early_valid_failed = 1'b0;
	logic valid_rise_failed = 1'b0;
	logic valid_sticky_failed = 1'b0;
	logic kernel_hold_failed = 1'b0;
	logic strobe_width_failed = 1'b0;
	logic failed;

	// some kernel has reached the queue since reset
	logic kernel_written;

	assign failed = early_valid_failed | valid_rise_failed | valid_sticky_failed |
		kernel_hold_failed | strobe_width_failed;

	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_written <= 1'b0;
		end else if (kernel_wr) begin
			kernel_written <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// valid flag
	//////////////////////////////////////////////////////////////////////

	early_valid: assert property (@(posedge clk) disable iff (reset)
		!kernel_written |-> !kernel_port.valid)
	else begin
		early_valid_failed = 1'b1;
		$error("kernel_port.valid is high before any kernel was queued");
	end

	valid_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(kernel_port.valid) |-> $past(load_weights))
	else begin
		valid_rise_failed = 1'b1;
		$error("kernel_port.valid rose without a load pulse");
	end

	valid_sticky: assert property (@(posedge clk) disable iff (reset)
		kernel_port.valid |=> kernel_port.valid)
	else begin
		valid_sticky_failed = 1'b1;
		$error("kernel_port.valid fell while out of reset");
	end

	//////////////////////////////////////////////////////////////////////
	// kernel data and write strobe
	//////////////////////////////////////////////////////////////////////

	kernel_hold: assert property (@(posedge clk) disable iff (reset)
		!load_weights |=> $stable(kernel_port.kernel))
	else begin
		kernel_hold_failed = 1'b1;
		$error("kernel_port.kernel changed without a load pulse");
	end

	// at least 49 words between two strobes
	strobe_width: assert property (@(posedge clk) disable iff (reset)
		kernel_wr |=> !kernel_wr)
	else begin
		strobe_width_failed = 1'b1;
		$error("kernel_wr stayed high for more than one cycle");
	end

endmodule

bind conv_weight_buffer conv_weight_buffer_assertions i_conv_weight_buffer_assertions (
	.clk          (clk),
	.reset        (reset),
	.load_weights (load_weights),
	.kernel_wr    (kernel_wr),
	.kernel_port  (kernel_port)
);

/* bench/conv_weight_buffer_tb.sv */
`include "conv_weight_config.svh"

module conv_weight_buffer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// ten kernels over all tests, at most four cycles per word
	localparam int kernel_count   = 10;
	localparam int timeout_cycles = kernel_count * `CWB_KERNEL_TAPS * 4 + 200;

	logic clk = 1'b0;
	logic reset;
	logic load_weights;

	conv_weight_pkg::weight_beat_t beat;
	conv_weight_pkg::kernel_port_t kernel_port;

	// model of the queue and of the output port
	conv_weight_pkg::kernel_t ref_q [$];
	conv_weight_pkg::kernel_t expected_kernel;
	logic expected_valid;

	int cycle_count = 0;

	conv_weight_buffer i_conv_weight_buffer (
		.clk          (clk),
		.reset        (reset),
		.beat         (beat),
		.load_weights (load_weights),
		.kernel_port  (kernel_port)
	);

	always #2 clk = ~clk;

	// run limit and watch on the bound assertions
	always @(negedge clk) begin
		cycle_count <= cycle_count + 1;
		if (i_conv_weight_buffer.i_conv_weight_buffer_assertions.failed) begin
			$display("a protocol assertion failed near cycle %0d", cycle_count);
			$display("Test failed");
			$fatal(1, "protocol assertion");
		end else if (cycle_count >= timeout_cycles) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	task automatic check_word(input string test_name,
		input conv_weight_pkg::weight_word_t expected,
		input conv_weight_pkg::weight_word_t actual);
		assert (actual == expected) else begin
			$display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
			$display("Test failed");
			$fatal(1, "data check");
		end
	endtask

	task automatic check_valid(input string test_name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s valid expected %0b actual %0b", test_name, expected, actual);
			$display("Test failed");
			$fatal(1, "valid check");
		end
	endtask

	// row r, column c is word 7r + c in arrival order
	task automatic check_port(input string test_name);
		check_valid(test_name, expected_valid, kernel_port.valid);
		for (int r = 0; r < `CWB_KERNEL_DIM; r++) begin
			for (int c = 0; c < `CWB_KERNEL_DIM; c++) begin
				check_word($sformatf("%s row %0d col %0d", test_name, r, c),
					expected_kernel.taps[r * `CWB_KERNEL_DIM + c],
					kernel_port.kernel.rows[r][c]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			beat.valid = 1'b0;
		end
	endtask

	task automatic feed_kernel(input int max_gap);
		conv_weight_pkg::kernel_t sent;
		int gap;
		sent = '0;
		for (int k = 0; k < `CWB_KERNEL_TAPS; k++) begin
			gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
			idle_cycles(gap);
			@(negedge clk);
			beat.valid = 1'b1;
			beat.data = $urandom;
			sent.taps[k] = beat.data;
		end
		// a full queue drops the kernel
		if (ref_q.size() < `CWB_KERNEL_DEPTH) begin
			ref_q.push_back(sent);
		end
	endtask

	task automatic load_kernel(input string test_name);
		@(negedge clk);
		beat.valid = 1'b0;
		load_weights = 1'b1;
		@(negedge clk);
		load_weights = 1'b0;
		if (ref_q.size() > 0) begin
			expected_kernel = ref_q.pop_front();
			expected_valid = 1'b1;
		end
		check_port(test_name);
	endtask

	initial begin
		void'($urandom(55));
		reset = 1'b1;
		beat = '0;
		load_weights = 1'b0;
		expected_kernel = '0;
		expected_valid = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;

		idle_cycles(2);
		load_kernel("empty load");

		feed_kernel(3);
		idle_cycles(3);
		load_kernel("one kernel");

		repeat (4) feed_kernel(0);
		idle_cycles(3);
		repeat (4) load_kernel("queue order");

		// fifth kernel arrives with the queue full
		repeat (5) feed_kernel(0);
		idle_cycles(3);
		repeat (4) load_kernel("overflow");
		load_kernel("load after overflow");

		idle_cycles(4);
		if (i_conv_weight_buffer.i_conv_weight_buffer_assertions.failed) begin
			$display("a protocol assertion failed before the end of the run");
			$display("Test failed");
			$fatal(1, "protocol assertion");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* conv_weight_buffer.f */
+incdir+hdl
hdl/conv_weight_pkg.sv
hdl/kernel_assembler.sv
hdl/kernel_fifo.sv
hdl/conv_weight_buffer.sv
bench/conv_weight_buffer_assertions.sv
bench/conv_weight_buffer_tb.sv

/* Makefile */
# Verilator build and run for the weight buffer testbench

VERILATOR ?= verilator
TOP       ?= conv_weight_buffer_tb
FILELIST  ?= conv_weight_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG) || \
		! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
